// File: Makefile
# Verilator build and run of the bus interface testbench.

VERILATOR ?= verilator
TOP       ?= bus_interface_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
PASS_MSG  ?= TB PASSED

SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/bus_interface_top.sv
// Dynamic bus sizing interface, top level.
// Sequencer, four byte lanes and the read collector.
`timescale 1ns/10ps
`default_nettype none

`include "bus_if_config.svh"

module bus_interface_top (
    input  logic                   CLK,
    input  logic                   RESET_CPU_I,
    input  core_pkg::core_req_t    core_req,
    input  logic [`BUS_DATA_W-1:0] data_from_core,
    output logic [`BUS_DATA_W-1:0] data_to_core,
    output logic                   data_rdy,
    output logic [`BUS_ADR_W-1:0]  adr_out,
    output logic [1:0]             size,
    output bus_pkg::bus_strobes_t  strobes,
    output logic [`BUS_DATA_W-1:0] data_port_out,
    output logic                   bus_bsy,
    input  logic [`BUS_DATA_W-1:0] data_port_in,
    input  logic [1:0]             dsack_n
);

    import bus_pkg::*;

    lane_plan_t             plan;
    logic [`BUS_DATA_W-1:0] wr_word;
    logic [`BUS_DATA_W-1:0] op_bytes;      // Operand byte i at bits 8i+7:8i.
    logic                   last_cycle;

    cycle_sequencer u_sequencer (
        .CLK            (CLK),
        .RESET_CPU_I    (RESET_CPU_I),
        .core_req       (core_req),
        .data_from_core (data_from_core),
        .dsack_n        (dsack_n),
        .plan           (plan),
        .wr_word        (wr_word),
        .adr_out        (adr_out),
        .size           (size),
        .strobes        (strobes),
        .bus_bsy        (bus_bsy),
        .last_cycle     (last_cycle)
    );

    // Physical lane i drives D(31-8i):(24-8i), its register holds operand byte i.
    for (genvar i = 0; i < `BUS_LANES; i++) begin : g_lane
        byte_lane #(
            .LANE (i)
        ) u_lane (
            .CLK           (CLK),
            .RESET_CPU_I   (RESET_CPU_I),
            .plan          (plan),
            .wr_word       (wr_word),
            .port_byte_in  (data_port_in),
            .port_byte_out (data_port_out[(`BUS_LANES-1-i)*`BUS_BYTE_W +: `BUS_BYTE_W]),
            .op_byte       (op_bytes[i*`BUS_BYTE_W +: `BUS_BYTE_W])
        );
    end

    read_collector u_collector (
        .CLK          (CLK),
        .RESET_CPU_I  (RESET_CPU_I),
        .op_bytes     (op_bytes),
        .last_cycle   (last_cycle),
        .op_size      (core_req.op_size),
        .data_to_core (data_to_core),
        .data_rdy     (data_rdy)
    );

endmodule

`default_nettype wire

// File: design/bus_pkg.sv
// Bus side types of the dynamic bus sizing interface.
// Port width, per-cycle lane plan and the bus control strobes.
`default_nettype none

`include "bus_if_config.svh"

package bus_pkg;

    // Width of the responding port.
    // The codes are the DSACKn values that announce them.
    typedef enum logic [1:0] {
        PW_32 = 2'b00,
        PW_16 = 2'b01,
        PW_8  = 2'b10
    } port_width_t;

    // Active low bus control strobes.
    typedef struct packed {
        logic as_n;     // Address strobe.
        logic ds_n;     // Data strobe.
        logic ecs_n;    // External cycle start.
        logic rw_n;     // Low for a write.
        logic dben_n;   // Data buffer enable.
    } bus_strobes_t;

    // What every byte lane needs to know about the current bus cycle.
    typedef struct packed {
        port_width_t           pw;        // Port width for this cycle.
        logic [1:0]            adr_lo;    // A1:A0 of this cycle.
        logic [`BUS_CNT_W-1:0] remain;    // Bytes left before this cycle, R.
        logic                  capture;   // Read lanes are valid at this edge.
    } lane_plan_t;

endpackage

`default_nettype wire

// File: design/byte_lane.sv
// One data bus byte lane. Drives its lane from the write buffer and
// captures the read byte that belongs in operand byte LANE.
`timescale 1ns/10ps
`default_nettype none

`include "bus_if_config.svh"

module byte_lane #(
    parameter int LANE = 0
) (
    input  logic                                   CLK,
    input  logic                                   RESET_CPU_I,
    input  bus_pkg::lane_plan_t                    plan,
    input  logic [`BUS_DATA_W-1:0]                 wr_word,
    input  logic [`BUS_LANES-1:0][`BUS_BYTE_W-1:0] port_byte_in,
    output logic [`BUS_BYTE_W-1:0]                 port_byte_out,
    output logic [`BUS_BYTE_W-1:0]                 op_byte
);

    import bus_pkg::*;

    localparam logic [`BUS_CNT_W-1:0] LANE_C   = `BUS_CNT_W'(LANE);
    localparam logic [1:0]            LANE_TOP = 2'(`BUS_LANES - 1);

    logic [`BUS_CNT_W-1:0] wr_base;
    logic [`BUS_CNT_W-1:0] wr_j;       // Transfer index carried on this lane.
    logic [1:0]            wr_idx;
    logic                  wr_used;
    logic [`BUS_CNT_W-1:0] rd_start;
    logic [`BUS_CNT_W-1:0] rd_end;
    logic [`BUS_CNT_W-1:0] rd_j;       // Transfer index that lands in byte LANE.
    logic [`BUS_CNT_W-1:0] src;
    logic [1:0]            src_lane;
    logic                  rd_hit;

    // ------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------
    // Lane 0 always starts a port, lane 1 starts a 16-bit one on odd addresses.
    // Placed this way, any port width finds its bytes on its own lanes.
    always_comb begin
        if (LANE == 0) begin
            wr_base = '0;
        end else if (LANE == 1) begin
            wr_base = `BUS_CNT_W'(plan.adr_lo[0]);
        end else begin
            wr_base = `BUS_CNT_W'(plan.adr_lo);
        end
    end

    assign wr_j    = LANE_C - wr_base;
    assign wr_used = (LANE_C >= wr_base) && (wr_j < plan.remain);
    assign wr_idx  = 2'(plan.remain - `BUS_CNT_W'(1) - wr_j);   // Byte R-1-j.

    assign port_byte_out = wr_used ? wr_word[wr_idx*`BUS_BYTE_W +: `BUS_BYTE_W] : '0;

    // ------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------
    always_comb begin
        case (plan.pw)
            PW_16: begin
                rd_start = `BUS_CNT_W'(plan.adr_lo[0]);
                rd_end   = `BUS_CNT_W'(2);
            end
            PW_8: begin
                rd_start = '0;
                rd_end   = `BUS_CNT_W'(1);
            end
            default: begin
                rd_start = `BUS_CNT_W'(plan.adr_lo);
                rd_end   = `BUS_CNT_W'(4);
            end
        endcase
    end

    assign rd_j     = plan.remain - `BUS_CNT_W'(1) - LANE_C;
    assign src      = rd_start + rd_j;
    assign src_lane = src[1:0];
    assign rd_hit   = (LANE_C < plan.remain) && (src < rd_end);

    always_ff @(posedge CLK) begin
        if (RESET_CPU_I) begin
            op_byte <= '0;
        end else if (plan.capture && rd_hit) begin
            op_byte <= port_byte_in[LANE_TOP - src_lane];   // Lane 0 is the top byte.
        end
    end

endmodule

`default_nettype wire

// File: design/core_pkg.sv
// Core side types of the dynamic bus sizing interface.
// Operand size and the request that the core holds until data_rdy.
`default_nettype none

`include "bus_if_config.svh"

package core_pkg;

    // Operand size, coded like the SIZE outputs.
    typedef enum logic [1:0] {
        OP_LONG = 2'b00,
        OP_BYTE = 2'b01,
        OP_WORD = 2'b10
    } op_size_t;

    // Request level from the core.
    typedef struct packed {
        logic                  rd_req;
        logic                  wr_req;
        op_size_t              op_size;
        logic [`BUS_ADR_W-1:0] adr;       // Address of the first operand byte.
    } core_req_t;

endpackage

`default_nettype wire

// File: design/cycle_sequencer.sv
// Bus cycle sequencer. Runs the IDLE/T1/T2/T3 machine, splits the operand
// into port-sized cycles and drives address, SIZE, strobes and the lane plan.
`timescale 1ns/10ps
`default_nettype none

`include "bus_if_config.svh"

module cycle_sequencer (
    input  logic                   CLK,
    input  logic                   RESET_CPU_I,
    input  core_pkg::core_req_t    core_req,
    input  logic [`BUS_DATA_W-1:0] data_from_core,
    input  logic [1:0]             dsack_n,
    output bus_pkg::lane_plan_t    plan,
    output logic [`BUS_DATA_W-1:0] wr_word,
    output logic [`BUS_ADR_W-1:0]  adr_out,
    output logic [1:0]             size,
    output bus_pkg::bus_strobes_t  strobes,
    output logic                   bus_bsy,
    output logic                   last_cycle
);

    import bus_pkg::*;
    import core_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        T1,
        T2,
        T3
    } seq_state_t;

    seq_state_t            state;
    seq_state_t            state_nxt;
    logic [`BUS_CNT_W-1:0] remain;       // Bytes still to move, R.
    logic [`BUS_CNT_W-1:0] offset;       // Accumulated address offset.
    logic [`BUS_CNT_W-1:0] init_cnt;     // R at the start of a transfer.
    logic [`BUS_CNT_W-1:0] port_room;    // Port lanes from the start lane to the top.
    logic [`BUS_CNT_W-1:0] step;         // Bytes moved by this cycle, n.
    port_width_t           pw_q;
    logic                  is_write;
    logic                  done_q;       // First IDLE clock after a transfer.
    logic                  start;
    logic                  acked;

    assign acked = (dsack_n != 2'b11);
    assign start = (core_req.rd_req || core_req.wr_req) && !done_q;

    // ------------------------------------------------------------
    // Size partitioning
    // ------------------------------------------------------------
    always_comb begin
        case (core_req.op_size)
            OP_LONG: init_cnt = `BUS_CNT_W'(4);
            OP_WORD: init_cnt = `BUS_CNT_W'(2);
            default: init_cnt = `BUS_CNT_W'(1);
        endcase
    end

    // Lanes left in the latched port, counted from the start lane.
    always_comb begin
        case (pw_q)
            PW_16:   port_room = `BUS_CNT_W'(2 - adr_out[0]);
            PW_8:    port_room = `BUS_CNT_W'(1);
            default: port_room = `BUS_CNT_W'(4 - adr_out[1:0]);
        endcase
    end

    assign step = (remain < port_room) ? remain : port_room;

    // ------------------------------------------------------------
    // State machine and counters
    // ------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = T1;
                end
            end
            T1: state_nxt = T2;
            T2: begin
                if (acked) begin             // Otherwise a wait state.
                    state_nxt = T3;
                end
            end
            T3: state_nxt = (remain == step) ? IDLE : T1;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET_CPU_I) begin
            state    <= IDLE;
            remain   <= '0;
            offset   <= '0;
            pw_q     <= PW_32;
            is_write <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            state  <= state_nxt;
            done_q <= last_cycle;
            if (state == IDLE && start) begin
                remain   <= init_cnt;
                offset   <= '0;
                is_write <= core_req.wr_req;
            end
            if (state == T2 && acked) begin
                pw_q <= port_width_t'(dsack_n);   // Port width latch.
            end
            if (state == T3) begin
                remain <= remain - step;
                offset <= offset + step;
            end
        end
    end

    // Write buffer, stable for the whole transfer.
    always_ff @(posedge CLK) begin
        if (state == IDLE && start) begin
            wr_word <= data_from_core;
        end
    end

    // ------------------------------------------------------------
    // Bus outputs
    // ------------------------------------------------------------
    assign adr_out    = core_req.adr + `BUS_ADR_W'(offset);
    assign size       = remain[1:0];          // R modulo 4.
    assign bus_bsy    = (state != IDLE);
    assign last_cycle = (state == T3) && (remain == step);

    assign strobes.ecs_n  = (state != T1);
    assign strobes.as_n   = (state != T2);
    assign strobes.ds_n   = (state != T2);
    assign strobes.dben_n = (state != T2);
    assign strobes.rw_n   = !(is_write && state != IDLE);   // Low from T1 through T3.

    // The lanes see the width on DSACKn at the capture edge itself.
    assign plan.pw      = (state == T2 && acked) ? port_width_t'(dsack_n) : pw_q;
    assign plan.adr_lo  = adr_out[1:0];
    assign plan.remain  = remain;
    assign plan.capture = (state == T2) && acked && !is_write;

endmodule

`default_nettype wire

// File: design/read_collector.sv
// Read collector. Zero-extends the assembled operand, registers it
// and pulses data_rdy once a transfer has finished.
`timescale 1ns/10ps
`default_nettype none

`include "bus_if_config.svh"

module read_collector (
    input  logic                   CLK,
    input  logic                   RESET_CPU_I,
    input  logic [`BUS_DATA_W-1:0] op_bytes,
    input  logic                   last_cycle,
    input  core_pkg::op_size_t     op_size,
    output logic [`BUS_DATA_W-1:0] data_to_core,
    output logic                   data_rdy
);

    import core_pkg::*;

    localparam int WORD_W = 2 * `BUS_BYTE_W;

    logic [`BUS_DATA_W-1:0] operand;

    // Bytes above the operand may hold data of an older transfer.
    always_comb begin
        case (op_size)
            OP_BYTE: operand = {{(`BUS_DATA_W-`BUS_BYTE_W){1'b0}}, op_bytes[`BUS_BYTE_W-1:0]};
            OP_WORD: operand = {{(`BUS_DATA_W-WORD_W){1'b0}}, op_bytes[WORD_W-1:0]};
            default: operand = op_bytes;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (last_cycle) begin
            data_to_core <= operand;
        end
    end

    // One clock, in the first IDLE clock.
    always_ff @(posedge CLK) begin
        if (RESET_CPU_I) begin
            data_rdy <= 1'b0;
        end else begin
            data_rdy <= last_cycle;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
design/bus_pkg.sv
design/core_pkg.sv
design/cycle_sequencer.sv
design/byte_lane.sv
design/read_collector.sv
design/bus_interface_top.sv
test/bus_interface_assertions.sv
test/bus_interface_tb.sv

// File: include/bus_if_config.svh
// Bus interface configuration.
// Widths of the address bus, the data bus, its byte lanes and the transfer counters.

`ifndef BUS_IF_CONFIG_SVH
`define BUS_IF_CONFIG_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------
`define BUS_ADR_W   32      // Address bus.
`define BUS_DATA_W  32      // Data bus and operand register.

// ------------------------------------------------------------
// Byte lanes
// ------------------------------------------------------------
`define BUS_LANES   4       // Lane 0 is D31:24.
`define BUS_BYTE_W  8

// Remaining-byte count and offset step.
// Must hold the value 4 for a long operand.
`define BUS_CNT_W   3

`endif

// File: test/bus_interface_assertions.sv
// Bus interface checks bound into the top level.
// Strobe order, RWn stability, bus busy and the data_rdy pulse.
`timescale 1ns/10ps
`default_nettype none

module bus_interface_assertions (
    input  logic                  CLK,
    input  logic                  RESET_CPU_I,
    input  bus_pkg::bus_strobes_t strobes,
    input  logic                  bus_bsy,
    input  logic                  data_rdy
);

    // ------------------------------------------------------------
    // Strobes
    // ------------------------------------------------------------
    // ECSn marks T1, ahead of the address strobe.
    ecs_before_as: assert property (@(posedge CLK) disable iff (RESET_CPU_I)
        !strobes.ecs_n |-> strobes.as_n)
        else $error("ECSn low together with ASn");

    rw_stable: assert property (@(posedge CLK) disable iff (RESET_CPU_I)
        !strobes.as_n |-> $stable(strobes.rw_n))
        else $error("RWn changed while ASn is low");

    busy_with_as: assert property (@(posedge CLK) disable iff (RESET_CPU_I)
        !strobes.as_n |-> bus_bsy)
        else $error("bus_bsy low while ASn is low");

    // One clock per transfer.
    rdy_pulse: assert property (@(posedge CLK) disable iff (RESET_CPU_I)
        data_rdy |=> !data_rdy)
        else $error("data_rdy high for two clocks");

endmodule

`default_nettype wire

// File: test/bus_interface_tb.sv
// Testbench for the dynamic bus sizing interface.
// Random core transfers against a port memory of random width and wait states.
`timescale 1ns/10ps
`default_nettype none

`include "bus_if_config.svh"

module bus_interface_tb;

    import bus_pkg::*;
    import core_pkg::*;

    localparam int N_XFER       = 200;
    localparam int CLK_PER_XFER = 20;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_CYCLES   = N_XFER * CLK_PER_XFER + RESET_CYCLES + 10;
    localparam int MEM_BYTES    = 64;

    logic                   CLK;
    logic                   RESET_CPU_I;
    core_req_t              core_req;
    logic [`BUS_DATA_W-1:0] data_from_core;
    logic [`BUS_DATA_W-1:0] data_to_core;
    logic                   data_rdy;
    logic [`BUS_ADR_W-1:0]  adr_out;
    logic [1:0]             size;
    bus_strobes_t           strobes;
    logic [`BUS_DATA_W-1:0] data_port_out;
    logic                   bus_bsy;
    logic [`BUS_DATA_W-1:0] data_port_in;
    logic [1:0]             dsack_n;

    logic [7:0]  port_mem  [MEM_BYTES];   // Memory behind the port.
    logic [7:0]  model_mem [MEM_BYTES];   // Expected memory image.
    logic [31:0] exp_adr_q [$];
    logic [1:0]  exp_size_q [$];
    logic [31:0] cyc_adr;                 // Expected address of the current bus cycle.
    logic [1:0]  cyc_size;                // Expected SIZE of the current bus cycle.
    int          port_bytes;              // Port width in bytes for this transfer.
    logic [1:0]  port_ack;                // DSACKn code of that width.
    logic        cur_write;
    logic        as_prev;
    logic        ecs_prev;
    int          waits;
    int          cycle_cnt;
    int          rdy_cnt;
    int          clk_cnt;

    bus_interface_top u_bus_interface_top (
        .CLK            (CLK),
        .RESET_CPU_I    (RESET_CPU_I),
        .core_req       (core_req),
        .data_from_core (data_from_core),
        .data_to_core   (data_to_core),
        .data_rdy       (data_rdy),
        .adr_out        (adr_out),
        .size           (size),
        .strobes        (strobes),
        .data_port_out  (data_port_out),
        .bus_bsy        (bus_bsy),
        .data_port_in   (data_port_in),
        .dsack_n        (dsack_n)
    );

    bind bus_interface_top bus_interface_assertions u_assertions (
        .CLK         (CLK),
        .RESET_CPU_I (RESET_CPU_I),
        .strobes     (strobes),
        .bus_bsy     (bus_bsy),
        .data_rdy    (data_rdy)
    );

    always #20 CLK = ~CLK;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // First lane the port uses at this address.
    function automatic int first_lane(input int adr, input int pbytes);
        first_lane = (pbytes == 4) ? adr % 4 : (pbytes == 2) ? adr % 2 : 0;
    endfunction

    always @(posedge CLK) begin
        clk_cnt++;
        if (clk_cnt >= MAX_CYCLES) begin
            abort_run("Timeout: the transfers did not finish within the cycle limit.");
        end
    end

    // ------------------------------------------------------------
    // Port model, answers in T2 after its wait states
    // ------------------------------------------------------------
    always @(negedge CLK) begin : port_model
        logic [7:0] lane_b [4];
        int         a;
        int         s;
        int         r;
        int         n;
        if (!RESET_CPU_I) begin
            if (data_rdy) begin
                rdy_cnt++;
            end
            if (!strobes.as_n && as_prev) begin
                if (exp_adr_q.size() == 0) begin
                    abort_run("More bus cycles than the model expects.");
                end else begin
                    cyc_adr  = exp_adr_q.pop_front();
                    cyc_size = exp_size_q.pop_front();
                    compare("ecs_n in T1", 32'(0), 32'(ecs_prev));
                    cycle_cnt++;
                    waits = $urandom_range(3, 0);
                end
            end
            if (!strobes.as_n) begin
                // Held for every clock of T2, wait states included.
                compare("cycle address", cyc_adr, adr_out);
                compare("cycle size", 32'(cyc_size), 32'(size));
                compare("ds_n in T2", 32'(0), 32'(strobes.ds_n));
                compare("dben_n in T2", 32'(0), 32'(strobes.dben_n));
                compare("rw_n in T2", 32'(!cur_write), 32'(strobes.rw_n));
                if (waits > 0) begin
                    waits--;                      // Wait state.
                    dsack_n = 2'b11;
                end else begin
                    a = int'(adr_out[5:0]);
                    s = first_lane(a, port_bytes);
                    r = (size == 2'd0) ? 4 : int'(size);
                    n = (r < port_bytes - s) ? r : port_bytes - s;
                    if (cur_write) begin
                        for (int j = 0; j < n; j++) begin
                            port_mem[6'(a + j)] = 8'(data_port_out >> (8 * (3 - (s + j))));
                        end
                    end else begin
                        for (int k = 0; k < 4; k++) begin
                            lane_b[k] = 8'($urandom);     // Lanes outside the port float.
                        end
                        for (int k = 0; k < port_bytes; k++) begin
                            lane_b[k] = port_mem[6'(a - s + k)];
                        end
                        data_port_in = {lane_b[0], lane_b[1], lane_b[2], lane_b[3]};
                    end
                    dsack_n = port_ack;
                end
            end else begin
                dsack_n = 2'b11;
            end
            as_prev  = strobes.as_n;
            ecs_prev = strobes.ecs_n;
        end
    end

    // ------------------------------------------------------------
    // One random transfer against the reference model
    // ------------------------------------------------------------
    task automatic run_transfer();
        int          kind;
        int          pw;
        int          a;
        int          nbytes;
        int          cur;
        int          r;
        int          s;
        int          n;
        int          n_exp;
        logic        is_wr;
        logic [31:0] wdata;
        logic [31:0] exp_val;
        string       name;
        kind   = $urandom_range(2, 0);
        pw     = $urandom_range(2, 0);
        a      = $urandom_range(MEM_BYTES - 4, 0);
        is_wr  = 1'($urandom_range(1, 0));
        wdata  = $urandom;
        nbytes = (kind == 0) ? 1 : (kind == 1) ? 2 : 4;
        port_bytes = (pw == 0) ? 4 : (pw == 1) ? 2 : 1;
        port_ack   = (pw == 0) ? 2'b00 : (pw == 1) ? 2'b01 : 2'b10;
        name = $sformatf("%s %0d bytes at %0d, %0d-bit port", is_wr ? "write" : "read",
                         nbytes, a, port_bytes * 8);
        // Split the operand into bus cycles.
        n_exp = 0;
        r     = nbytes;
        cur   = a;
        while (r > 0) begin
            s = first_lane(cur, port_bytes);
            n = (r < port_bytes - s) ? r : port_bytes - s;
            exp_adr_q.push_back(32'(cur));
            exp_size_q.push_back(2'(r % 4));
            n_exp++;
            cur += n;
            r   -= n;
        end
        // Operand byte 0 is the most significant and sits at the lowest address.
        exp_val = '0;
        for (int i = 0; i < nbytes; i++) begin
            if (is_wr) begin
                model_mem[6'(a + i)] = 8'(wdata >> (8 * (nbytes - 1 - i)));
            end else begin
                exp_val = {exp_val[23:0], model_mem[6'(a + i)]};
            end
        end
        cycle_cnt = 0;
        rdy_cnt   = 0;
        cur_write = is_wr;
        core_req.rd_req  = !is_wr;
        core_req.wr_req  = is_wr;
        core_req.op_size = (kind == 0) ? OP_BYTE : (kind == 1) ? OP_WORD : OP_LONG;
        core_req.adr     = 32'(a);
        data_from_core   = wdata;
        @(negedge CLK);
        while (!data_rdy) begin
            @(negedge CLK);
        end
        if (!is_wr) begin
            compare(name, exp_val, data_to_core);
        end
        compare({name, ", bus_bsy at data_rdy"}, 32'(0), 32'(bus_bsy));
        core_req.rd_req = 1'b0;
        core_req.wr_req = 1'b0;
        @(negedge CLK);
        compare({name, ", data_rdy pulses"}, 32'(1), 32'(rdy_cnt));
        compare({name, ", bus cycles"}, 32'(n_exp), 32'(cycle_cnt));
        for (int i = 0; i < MEM_BYTES; i++) begin
            compare($sformatf("%s, mem[%0d]", name, i), 32'(model_mem[i]), 32'(port_mem[i]));
        end
    endtask

    initial begin
        void'($urandom(32'hf809));
        CLK            = 1'b0;
        RESET_CPU_I    = 1'b1;
        core_req       = '0;
        data_from_core = '0;
        data_port_in   = '0;
        dsack_n        = 2'b11;
        port_bytes     = 4;
        port_ack       = 2'b00;
        cur_write      = 1'b0;
        as_prev        = 1'b1;
        ecs_prev       = 1'b1;
        cyc_adr        = '0;
        cyc_size       = '0;
        waits          = 0;
        cycle_cnt      = 0;
        rdy_cnt        = 0;
        clk_cnt        = 0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            port_mem[i]  = 8'($urandom);
            model_mem[i] = port_mem[i];
        end
        repeat (RESET_CYCLES) @(negedge CLK);
        RESET_CPU_I = 1'b0;
        compare("strobes after reset", 32'h1f, 32'(strobes));
        compare("bus_bsy after reset", 32'(0), 32'(bus_bsy));
        compare("data_rdy after reset", 32'(0), 32'(data_rdy));
        repeat (N_XFER) run_transfer();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
